/* source/offload_pkg.sv */
/*
  Offload package
  Sizes, funct3 codes and the instruction word view shared by the offload path
*/
package offload_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int unsigned NUM_LANES = 4;
  localparam int unsigned LANE_SEL_W = 2;

  // Id 0 means no write-back to the core
  localparam int unsigned ID_W = 5;
  localparam int unsigned DATA_W = 32;

  localparam int unsigned NUM_CFG_REGS = 8;
  localparam int unsigned CFG_IDX_W = 3;

  // --------------------
  // funct3 codes
  // --------------------
  // Address from the immediate
  localparam logic [2:0] FN_READ_IMM = 3'b001;
  localparam logic [2:0] FN_WRITE_IMM = 3'b010;

  // Address from operand B
  localparam logic [2:0] FN_READ_REG = 3'b101;
  localparam logic [2:0] FN_WRITE_REG = 3'b110;

  // --------------------
  // Instruction word
  // --------------------
  // Raw word as issued by the core, or its I-type fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
  } offload_op_u;

endpackage

/* source/offload_dispatch.sv */
/*
  Offload dispatcher
  Steers one request to the lane named by its select field
*/
`timescale 1ns/1ps

module offload_dispatch (
  input  logic                                req_valid_i,
  input  logic [offload_pkg::LANE_SEL_W-1:0]  req_sel_i,
  output logic                                req_ready_o,
  output logic [offload_pkg::NUM_LANES-1:0]   lane_valid_o,
  input  logic [offload_pkg::NUM_LANES-1:0]   lane_ready_i
);

  // --------------------
  // Select decode
  // --------------------
  // Only the selected lane sees valid
  always_comb begin
    lane_valid_o = '0;
    lane_valid_o[req_sel_i] = req_valid_i;
  end

  // Handshake completes on the selected lane's ready
  assign req_ready_o = lane_ready_i[req_sel_i];

endmodule

/* source/cfg_lane.sv */
/*
  Configuration lane
  Bank of configuration registers read or written by offloaded instructions,
  with the answer held in a one-entry response buffer
*/
`timescale 1ns/1ps

module cfg_lane (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic [offload_pkg::ID_W-1:0]     req_id_i,
  input  offload_pkg::offload_op_u         req_op_i,
  input  logic [offload_pkg::DATA_W-1:0]   req_arga_i,
  input  logic [offload_pkg::DATA_W-1:0]   req_argb_i,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output logic [offload_pkg::ID_W-1:0]     rsp_id_o,
  output logic [offload_pkg::DATA_W-1:0]   rsp_data_o,
  output logic                             rsp_error_o
);

  import offload_pkg::*;

  logic [DATA_W-1:0]    cfg_q [NUM_CFG_REGS];
  logic [CFG_IDX_W-1:0] cfg_idx;
  logic                 is_write;
  logic                 is_known;
  logic                 accept;

  logic                 rsp_valid_q;
  logic [ID_W-1:0]      rsp_id_q;
  logic [DATA_W-1:0]    rsp_data_q;
  logic                 rsp_error_q;

  // --------------------
  // Decode
  // --------------------
  // Immediate or operand B gives the address, low bits pick the register
  always_comb begin
    cfg_idx = '0;
    is_write = 1'b0;
    is_known = 1'b1;
    case (req_op_i.itype.funct3)
      FN_READ_IMM: cfg_idx = req_op_i.itype.imm[CFG_IDX_W-1:0];
      FN_WRITE_IMM: begin
        cfg_idx = req_op_i.itype.imm[CFG_IDX_W-1:0];
        is_write = 1'b1;
      end
      FN_READ_REG: cfg_idx = req_argb_i[CFG_IDX_W-1:0];
      FN_WRITE_REG: begin
        cfg_idx = req_argb_i[CFG_IDX_W-1:0];
        is_write = 1'b1;
      end
      default: is_known = 1'b0;
    endcase
  end

  // Buffer free, or emptied this cycle
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
  assign accept = req_valid_i & req_ready_o;

  // --------------------
  // Register bank
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      for (int i = 0; i < NUM_CFG_REGS; i++) begin
        cfg_q[i] <= '0;
      end
    end else if (accept && is_known && is_write) begin
      cfg_q[cfg_idx] <= req_arga_i;
    end
  end

  // --------------------
  // Response buffer
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Old register value, writes return id 0 so nothing is written back
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_id_q <= (is_known && is_write) ? '0 : req_id_i;
      rsp_data_q <= is_known ? cfg_q[cfg_idx] : '0;
      rsp_error_q <= ~is_known;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_id_o = rsp_id_q;
  assign rsp_data_o = rsp_data_q;
  assign rsp_error_o = rsp_error_q;

  // Stalled response stays put until taken
  assert property (@(posedge clk_i) disable iff (rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o) && $stable(rsp_id_o))
    else $error("cfg_lane: stalled response changed");

endmodule

/* source/rsp_arbiter.sv */
/*
  Response arbiter
  Round-robin merge of the lane responses into one registered output stream
*/
`timescale 1ns/1ps

module rsp_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [offload_pkg::NUM_LANES-1:0]                      in_valid_i,
  output logic [offload_pkg::NUM_LANES-1:0]                      in_ready_o,
  input  logic [offload_pkg::NUM_LANES-1:0][offload_pkg::ID_W-1:0]   in_id_i,
  input  logic [offload_pkg::NUM_LANES-1:0][offload_pkg::DATA_W-1:0] in_data_i,
  input  logic [offload_pkg::NUM_LANES-1:0]                      in_error_i,
  output logic                                                   out_valid_o,
  input  logic                                                   out_ready_i,
  output logic [offload_pkg::ID_W-1:0]                           out_id_o,
  output logic [offload_pkg::DATA_W-1:0]                         out_data_o,
  output logic                                                   out_error_o,
  output logic [offload_pkg::LANE_SEL_W-1:0]                     out_lane_o
);

  import offload_pkg::*;

  logic [LANE_SEL_W-1:0] rr_q;
  logic [LANE_SEL_W-1:0] grant_idx;
  logic                  found;
  logic                  load;
  logic                  grant;

  logic                  out_valid_q;
  logic [ID_W-1:0]       out_id_q;
  logic [DATA_W-1:0]     out_data_q;
  logic                  out_error_q;
  logic [LANE_SEL_W-1:0] out_lane_q;

  // --------------------
  // Lane pick
  // --------------------
  // First valid lane at or after the pointer
  always_comb begin
    logic [LANE_SEL_W-1:0] idx;
    found = 1'b0;
    grant_idx = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      idx = LANE_SEL_W'((int'(rr_q) + i) % NUM_LANES);
      if (!found && in_valid_i[idx]) begin
        found = 1'b1;
        grant_idx = idx;
      end
    end
  end

  // Output register empty or draining
  assign load = ~out_valid_q | out_ready_i;
  assign grant = found & load;

  always_comb begin
    in_ready_o = '0;
    in_ready_o[grant_idx] = grant;
  end

  // --------------------
  // Pointer and output register
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rr_q <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (grant) begin
        rr_q <= LANE_SEL_W'((int'(grant_idx) + 1) % NUM_LANES);
        out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      out_id_q <= in_id_i[grant_idx];
      out_data_q <= in_data_i[grant_idx];
      out_error_q <= in_error_i[grant_idx];
      out_lane_q <= grant_idx;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_id_o = out_id_q;
  assign out_data_o = out_data_q;
  assign out_error_o = out_error_q;
  assign out_lane_o = out_lane_q;

  // Single grant, and only to a lane that offers a response
  assert property (@(posedge clk_i) disable iff (rst_ni)
    $onehot0(in_ready_o) && ((in_ready_o & ~in_valid_i) == '0))
    else $error("rsp_arbiter: bad grant %b for valid %b", in_ready_o, in_valid_i);

endmodule

/* source/offload_complex.sv */
/*
  Offload complex top level
  Dispatches core offload requests to the configuration lanes and
  merges their responses back into one stream
*/
`timescale 1ns/1ps

module offload_complex (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  input  logic [offload_pkg::LANE_SEL_W-1:0] req_sel_i,
  input  logic [offload_pkg::ID_W-1:0]       req_id_i,
  input  logic [31:0]                        req_op_i,
  input  logic [offload_pkg::DATA_W-1:0]     req_arga_i,
  input  logic [offload_pkg::DATA_W-1:0]     req_argb_i,
  output logic                               rsp_valid_o,
  input  logic                               rsp_ready_i,
  output logic [offload_pkg::ID_W-1:0]       rsp_id_o,
  output logic [offload_pkg::DATA_W-1:0]     rsp_data_o,
  output logic                               rsp_error_o,
  output logic [offload_pkg::LANE_SEL_W-1:0] rsp_lane_o
);

  import offload_pkg::*;

  logic [NUM_LANES-1:0]             lane_valid;
  logic [NUM_LANES-1:0]             lane_ready;
  logic [NUM_LANES-1:0]             lane_rsp_valid;
  logic [NUM_LANES-1:0]             lane_rsp_ready;
  logic [NUM_LANES-1:0][ID_W-1:0]   lane_rsp_id;
  logic [NUM_LANES-1:0][DATA_W-1:0] lane_rsp_data;
  logic [NUM_LANES-1:0]             lane_rsp_error;

  // --------------------
  // Request side
  // --------------------
  offload_dispatch i_dispatch (
    .req_valid_i  (req_valid_i),
    .req_sel_i    (req_sel_i),
    .req_ready_o  (req_ready_o),
    .lane_valid_o (lane_valid),
    .lane_ready_i (lane_ready)
  );

  // Request payload fans out to every lane
  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane
    cfg_lane i_lane (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_valid_i (lane_valid[k]),
      .req_ready_o (lane_ready[k]),
      .req_id_i    (req_id_i),
      .req_op_i    (req_op_i),
      .req_arga_i  (req_arga_i),
      .req_argb_i  (req_argb_i),
      .rsp_valid_o (lane_rsp_valid[k]),
      .rsp_ready_i (lane_rsp_ready[k]),
      .rsp_id_o    (lane_rsp_id[k]),
      .rsp_data_o  (lane_rsp_data[k]),
      .rsp_error_o (lane_rsp_error[k])
    );
  end

  // --------------------
  // Response side
  // --------------------
  rsp_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (lane_rsp_valid),
    .in_ready_o  (lane_rsp_ready),
    .in_id_i     (lane_rsp_id),
    .in_data_i   (lane_rsp_data),
    .in_error_i  (lane_rsp_error),
    .out_valid_o (rsp_valid_o),
    .out_ready_i (rsp_ready_i),
    .out_id_o    (rsp_id_o),
    .out_data_o  (rsp_data_o),
    .out_error_o (rsp_error_o),
    .out_lane_o  (rsp_lane_o)
  );

endmodule

/* bench/tb_offload_complex.sv */
/*
  Offload complex testbench
  Random offload traffic under response back-pressure, checked against
  a register model of every lane, plus a lone-request latency check
*/
`timescale 1ns/1ps

module tb_offload_complex;

  import offload_pkg::*;

  localparam int NUM_REQS = 2000;
  localparam int NUM_LONE = 8;
  // About ten cycles per request covers stalls and back-pressure
  localparam int TIMEOUT_CYCLES = NUM_REQS * 10;
  // Expected entry is {lane, error, id, data}
  localparam int EXP_W = LANE_SEL_W + 1 + ID_W + DATA_W;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_valid_i;
  logic                  req_ready_o;
  logic [LANE_SEL_W-1:0] req_sel_i;
  logic [ID_W-1:0]       req_id_i;
  logic [31:0]           req_op_i;
  logic [DATA_W-1:0]     req_arga_i;
  logic [DATA_W-1:0]     req_argb_i;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;
  logic [ID_W-1:0]       rsp_id_o;
  logic [DATA_W-1:0]     rsp_data_o;
  logic                  rsp_error_o;
  logic [LANE_SEL_W-1:0] rsp_lane_o;

  logic [DATA_W-1:0] model_regs [NUM_LANES][NUM_CFG_REGS];
  logic [EXP_W-1:0]  exp_q [$];
  logic              bp_enable;
  int                cycle_cnt;
  int                rsp_count;

  offload_complex dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_sel_i   (req_sel_i),
    .req_id_i    (req_id_i),
    .req_op_i    (req_op_i),
    .req_arga_i  (req_arga_i),
    .req_argb_i  (req_argb_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_id_o    (rsp_id_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_error_o (rsp_error_o),
    .rsp_lane_o  (rsp_lane_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d responses outstanding",
               cycle_cnt, exp_q.size());
      $display("Test FAILED");
      $fatal(1, "run timed out");
    end
  end

  // Output ready low about 30% of the time while back-pressure is on
  always @(posedge clk_i) begin
    #1;
    if (bp_enable) begin
      rsp_ready_i = ($urandom_range(99) >= 30);
    end else begin
      rsp_ready_i = 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Old value comes back, writes carry no write-back id
  task automatic model_accept();
    offload_op_u          op;
    logic [2:0]           f3;
    logic                 from_reg;
    logic                 write;
    logic                 known;
    logic [CFG_IDX_W-1:0] idx;
    logic [ID_W-1:0]      exp_id;
    op.raw = req_op_i;
    f3 = op.itype.funct3;
    from_reg = (f3 == FN_READ_REG) || (f3 == FN_WRITE_REG);
    write = (f3 == FN_WRITE_IMM) || (f3 == FN_WRITE_REG);
    known = from_reg || write || (f3 == FN_READ_IMM);
    idx = from_reg ? req_argb_i[CFG_IDX_W-1:0] : op.itype.imm[CFG_IDX_W-1:0];
    if (!known) begin
      exp_q.push_back({req_sel_i, 1'b1, req_id_i, {DATA_W{1'b0}}});
    end else begin
      exp_id = write ? '0 : req_id_i;
      exp_q.push_back({req_sel_i, 1'b0, exp_id, model_regs[req_sel_i][idx]});
      if (write) begin
        model_regs[req_sel_i][idx] = req_arga_i;
      end
    end
  endtask

  // Oldest pending entry of the responding lane
  task automatic check_response();
    int               pos;
    logic [EXP_W-1:0] exp;
    pos = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (pos < 0 && exp_q[i][EXP_W-1 -: LANE_SEL_W] == rsp_lane_o) begin
        pos = i;
      end
    end
    if (pos < 0) begin
      $display("Lane %0d gave a response with id 0x%0h while none was pending",
               rsp_lane_o, rsp_id_o);
      $display("Test FAILED");
      $fatal(1, "unexpected response");
    end else begin
      exp = exp_q[pos];
      exp_q.delete(pos);
      check_value("rsp_error_o", 32'(rsp_error_o), 32'(exp[ID_W+DATA_W]));
      check_value("rsp_id_o", 32'(rsp_id_o), 32'(exp[DATA_W +: ID_W]));
      check_value("rsp_data_o", rsp_data_o, exp[DATA_W-1:0]);
      rsp_count++;
    end
  endtask

  // Handshakes sampled mid-cycle, they complete on the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni == 1'b0) begin
      if (req_valid_i && req_ready_o) begin
        model_accept();
      end
      if (rsp_valid_o && rsp_ready_i) begin
        check_response();
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic random_request();
    offload_op_u op;
    logic [31:0] rnd;
    int          pick;
    rnd = $urandom;
    pick = $urandom_range(9);
    op.raw = $urandom;
    op.itype.opcode = 7'b0101011;
    case (pick)
      0, 1: op.itype.funct3 = FN_READ_IMM;
      2, 3: op.itype.funct3 = FN_WRITE_IMM;
      4, 5: op.itype.funct3 = FN_READ_REG;
      6, 7: op.itype.funct3 = FN_WRITE_REG;
      // Any code, unknown ones included
      default: op.itype.funct3 = rnd[12:10];
    endcase
    req_sel_i = rnd[1:0];
    req_id_i = rnd[8:4];
    req_op_i = op.raw;
    req_arga_i = $urandom;
    req_argb_i = $urandom;
  endtask

  // Holds the request until accepted, returns just after that edge
  task automatic send_request();
    logic accepted;
    accepted = 1'b0;
    req_valid_i = 1'b1;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = req_ready_o;
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
  endtask

  // Idle complex, output ready held high
  task automatic measure_latency(input logic [LANE_SEL_W-1:0] lane);
    offload_op_u op;
    int          cycles;
    op.raw = $urandom;
    op.itype.opcode = 7'b0101011;
    op.itype.funct3 = FN_READ_IMM;
    req_sel_i = lane;
    req_id_i = ID_W'($urandom_range(31, 1));
    req_op_i = op.raw;
    req_arga_i = $urandom;
    req_argb_i = $urandom;
    send_request();
    // Edges from acceptance up to the one that takes the response
    cycles = 1;
    @(negedge clk_i);
    while (!rsp_valid_o && cycles < 10) begin
      @(posedge clk_i);
      cycles++;
      @(negedge clk_i);
    end
    check_value("latency", 32'(cycles), 32'd2);
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    void'($urandom(42293));
    cycle_cnt = 0;
    rsp_count = 0;
    bp_enable = 1'b0;
    rst_ni = 1'b1;
    req_valid_i = 1'b0;
    req_sel_i = '0;
    req_id_i = '0;
    req_op_i = '0;
    req_arga_i = '0;
    req_argb_i = '0;
    rsp_ready_i = 1'b1;
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int r = 0; r < NUM_CFG_REGS; r++) begin
        model_regs[l][r] = '0;
      end
    end

    // Reset is active high on rst_ni
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b0;
    @(negedge clk_i);
    check_value("req_ready_o", 32'(req_ready_o), 32'h1);
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    @(posedge clk_i);
    #1;

    bp_enable = 1'b1;
    for (int n = 0; n < NUM_REQS; n++) begin
      random_request();
      send_request();
      if ($urandom_range(9) < 2) begin
        @(posedge clk_i);
        #1;
      end
    end

    // Drain with ready high
    bp_enable = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    #1;

    for (int n = 0; n < NUM_LONE; n++) begin
      measure_latency(LANE_SEL_W'(n % NUM_LANES));
    end

    repeat (4) @(posedge clk_i);
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never came out", exp_q.size());
      $display("Test FAILED");
      $fatal(1, "responses lost");
    end else begin
      $display("Checked %0d responses", rsp_count);
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* all.f */
source/offload_pkg.sv
source/offload_dispatch.sv
source/cfg_lane.sv
source/rsp_arbiter.sv
source/offload_complex.sv
bench/tb_offload_complex.sv

/* Makefile */
# Verilator build for the offload complex testbench

TOP := tb_offload_complex

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

obj_dir/V$(TOP): all.f $(wildcard source/*.sv bench/*.sv)
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

# A $fatal in the testbench gives a non-zero exit status
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
